// File: hdl/spi_reg_config.svh
////////////////////
// spi register bank configuration
// frame geometry, peripheral count and select polarity
////////////////////

`ifndef SPI_REG_CONFIG_SVH
`define SPI_REG_CONFIG_SVH

////////////////////
// frame geometry

// bits in one complete spi frame
`define FRAME_BITS 16

// first byte of the frame is the register address
`define ADDR_BITS 8

////////////////////
// peripheral routing

// number of routed chip select lines
`define NUM_PERIPH 8

// 1 marks a select line that is active high
// 4094 strobes sit on lines 4 to 6
`define SEL_POLARITY 8'b0111_0000

`endif

// File: hdl/spi_reg_pkg.sv
////////////////////
// spi register bank types
// register addresses, frame layout, control register set
////////////////////

`include "spi_reg_config.svh"

package spi_reg_pkg;

  ////////////////////
  // address byte decode

  // plain registers plus two command addresses
  typedef enum logic [`ADDR_BITS-1:0] {
    // power-up clear command
    REG_PWRUP    = 8'd6,
    REG_LED      = 8'd7,
    // peripheral route select
    REG_ROUTE    = 8'd8,
    REG_AUX      = 8'd9,
    REG_DAC      = 8'd10,
    // soft reset command
    REG_SOFT_RST = 8'd11,
    REG_ADC      = 8'd14
  } reg_addr_e;

  ////////////////////
  // committed frame

  // addr arrives first so it sits in the upper byte
  typedef struct packed {
    reg_addr_e                        addr;
    logic [`FRAME_BITS-`ADDR_BITS-1:0] data;
  } spi_frame_t;

  ////////////////////
  // control outputs

  // four bit fields, each updated by set/clear/toggle
  typedef struct packed {
    logic [3:0] led;
    logic [3:0] aux;
    logic [3:0] dac;
    logic [3:0] adc;
  } ctrl_regs_t;

endpackage

// File: hdl/spi_frame_slave.sv
////////////////////
// spi frame slave
// samples the spi pins in the system clock, shifts in a
// 16 bit frame, shifts out read data, commits on select rise
////////////////////

`timescale 1ns/100ps

`include "spi_reg_config.svh"

module spi_frame_slave (
  input  logic                   cs,
  input  logic                   rst_n,
  input  logic                   sck,
  input  logic                   mosi,
  input  logic                   sel_n,
  output logic                   sdo,
  output spi_reg_pkg::reg_addr_e rd_addr,
  input  logic [7:0]             rd_data,
  output spi_reg_pkg::spi_frame_t frame,
  output logic                   frame_valid
);

  ////////////////////
  // pin synchronizers

  // [0] and [1] form the synchronizer, [2] holds the previous value
  logic [2:0] sck_q;
  logic [2:0] sel_q;
  logic [1:0] mosi_q;

  logic sck_rise;
  logic sck_fall;
  logic sel_rise;
  logic sel_idle;

  // bit counter saturates so long frames never wrap back to 16
  logic [4:0]             bit_cnt;
  logic [`FRAME_BITS-1:0] shift_in;
  logic [7:0]             shift_out;
  logic                   load_pend;

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_q  <= 3'b000;
      // select idles high
      sel_q  <= 3'b111;
      mosi_q <= 2'b00;
    end
    else
    begin
      sck_q  <= {sck_q[1:0], sck};
      sel_q  <= {sel_q[1:0], sel_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  // edges seen one cycle after the synchronizer output
  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign sel_rise = sel_q[1] & ~sel_q[2];
  assign sel_idle = sel_q[1];

  ////////////////////
  // shift in, shift out

  // low byte holds the address once 8 bits are in
  assign rd_addr = spi_reg_pkg::reg_addr_e'(shift_in[`ADDR_BITS-1:0]);

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt   <= '0;
      shift_in  <= '0;
      shift_out <= '0;
      load_pend <= 1'b0;
      sdo       <= 1'b0;
    end
    else if (sel_idle)
    begin
      // everything held cleared while not selected
      bit_cnt   <= '0;
      shift_in  <= '0;
      shift_out <= '0;
      load_pend <= 1'b0;
      sdo       <= 1'b0;
    end
    else
    begin
      load_pend <= 1'b0;

      // mosi sampled msb first on sck rise
      if (sck_rise)
      begin
        shift_in <= {shift_in[`FRAME_BITS-2:0], mosi_q[1]};
        if (bit_cnt != 5'h1f)
          bit_cnt <= bit_cnt + 5'd1;
        // 8th bit arriving completes the address byte next cycle
        if (bit_cnt == 5'(`ADDR_BITS - 1))
          load_pend <= 1'b1;
      end

      // read data captured the cycle after the 8th rise
      if (load_pend)
        shift_out <= rd_data;
      else if (sck_fall && bit_cnt >= 5'(`ADDR_BITS))
      begin
        // data phase shifts msb first with zero fill
        sdo       <= shift_out[7];
        shift_out <= {shift_out[6:0], 1'b0};
      end
    end
  end

  ////////////////////
  // frame commit

  // only an exact 16 bit frame is handed on
  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
      frame_valid <= 1'b0;
    else
      frame_valid <= sel_rise && (bit_cnt == 5'(`FRAME_BITS));
  end

  // payload qualified by frame_valid
  always_ff @(posedge cs)
  begin
    if (sel_rise)
      frame <= spi_reg_pkg::spi_frame_t'(shift_in);
  end

endmodule

// File: hdl/ctrl_reg_bank.sv
////////////////////
// control register bank
// set/clear/toggle registers, route register, commands
// and combinational read-back
////////////////////

`timescale 1ns/100ps

module ctrl_reg_bank (
  input  logic                    cs,
  input  logic                    rst_n,
  input  spi_reg_pkg::spi_frame_t frame,
  input  logic                    frame_valid,
  input  spi_reg_pkg::reg_addr_e  rd_addr,
  output logic [7:0]              rd_data,
  output logic [7:0]              route,
  output spi_reg_pkg::ctrl_regs_t ctrl
);

  // dac lines idle high out of reset
  localparam spi_reg_pkg::ctrl_regs_t CTRL_RESET = '{
    led: 4'h0,
    aux: 4'h0,
    dac: 4'hf,
    adc: 4'h0
  };

  ////////////////////
  // set/clear update

  // overlap of set and clear toggles those bits
  // otherwise set first, then clear wins
  function automatic logic [3:0] set_clr(
    input logic [3:0] old_val,
    input logic [3:0] set_bits,
    input logic [3:0] clr_bits
  );
    logic [3:0] both;
    both = set_bits & clr_bits;
    if (both != 4'h0)
      set_clr = old_val ^ both;
    else
      set_clr = (old_val | set_bits) & ~clr_bits;
  endfunction

  logic [3:0] set_bits;
  logic [3:0] clr_bits;

  // low nibble sets, high nibble clears
  assign set_bits = frame.data[3:0];
  assign clr_bits = frame.data[7:4];

  ////////////////////
  // write decode

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl  <= CTRL_RESET;
      // route 0 means no peripheral
      route <= 8'h00;
    end
    else if (frame_valid)
    begin
      case (frame.addr)
        spi_reg_pkg::REG_ROUTE:
          route <= frame.data;
        spi_reg_pkg::REG_LED:
          ctrl.led <= set_clr(ctrl.led, set_bits, clr_bits);
        spi_reg_pkg::REG_AUX:
          ctrl.aux <= set_clr(ctrl.aux, set_bits, clr_bits);
        spi_reg_pkg::REG_DAC:
          ctrl.dac <= set_clr(ctrl.dac, set_bits, clr_bits);
        spi_reg_pkg::REG_ADC:
          ctrl.adc <= set_clr(ctrl.adc, set_bits, clr_bits);
        spi_reg_pkg::REG_SOFT_RST:
        begin
          // aux kept across soft reset
          ctrl.led <= 4'h0;
          ctrl.dac <= 4'h0;
          ctrl.adc <= 4'h0;
          route    <= 8'h00;
        end
        spi_reg_pkg::REG_PWRUP:
        begin
          // dac already set up before rails come on, leave it
          ctrl.led <= 4'h0;
          ctrl.adc <= 4'h0;
        end
        default:
        begin
          // unknown address, nothing written
        end
      endcase
    end
  end

  ////////////////////
  // read-back

  // commands and unknown addresses read as zero
  always_comb
  begin
    rd_data = 8'h00;
    case (rd_addr)
      spi_reg_pkg::REG_LED:
        rd_data = {4'h0, ctrl.led};
      spi_reg_pkg::REG_AUX:
        rd_data = {4'h0, ctrl.aux};
      spi_reg_pkg::REG_DAC:
        rd_data = {4'h0, ctrl.dac};
      spi_reg_pkg::REG_ADC:
        rd_data = {4'h0, ctrl.adc};
      spi_reg_pkg::REG_ROUTE:
        rd_data = route;
      default:
        rd_data = 8'h00;
    endcase
  end

endmodule

// File: hdl/periph_router.sv
////////////////////
// peripheral router
// route value to one select line with per-line polarity
////////////////////

`timescale 1ns/100ps

`include "spi_reg_config.svh"

module periph_router (
  input  logic [7:0]             route,
  input  logic                   pass_n,
  input  logic [`NUM_PERIPH-1:0] periph_miso,
  output logic [`NUM_PERIPH-1:0] periph_sel,
  output logic                   periph_data
);

  logic [`NUM_PERIPH-1:0] hit;
  logic [`NUM_PERIPH-1:0] active;

  ////////////////////
  // route decode

  // value n picks line n-1
  // 0 and out of range values pick nothing
  always_comb
  begin
    hit = '0;
    for (int i = 0; i < `NUM_PERIPH; i++)
    begin
      if (route == 8'(i + 1))
        hit[i] = 1'b1;
    end
  end

  // only asserted during pass-through
  assign active = hit & {`NUM_PERIPH{~pass_n}};

  // xor with polarity, then invert
  // active low lines idle high, active high lines idle low
  assign periph_sel = ~(active ^ `SEL_POLARITY);

  ////////////////////
  // miso return

  // at most one bit of active is set
  assign periph_data = |(active & periph_miso);

endmodule

// File: hdl/spi_reg_top.sv
////////////////////
// spi register bank top
// frame slave, control registers, peripheral router
// and the shared miso output
////////////////////

`timescale 1ns/100ps

`include "spi_reg_config.svh"

module spi_reg_top (
  input  logic                    cs,
  input  logic                    rst_n,
  input  logic                    sck,
  input  logic                    mosi,
  input  logic                    sel_n,
  input  logic                    pass_n,
  input  logic [`NUM_PERIPH-1:0]  periph_miso,
  output logic                    miso,
  output logic [`NUM_PERIPH-1:0]  periph_sel,
  output spi_reg_pkg::ctrl_regs_t ctrl
);

  // slave to bank
  spi_reg_pkg::spi_frame_t frame;
  logic                    frame_valid;
  spi_reg_pkg::reg_addr_e  rd_addr;
  logic [7:0]              rd_data;

  // bank to router
  logic [7:0] route;

  // miso sources
  logic sdo;
  logic periph_data;

  ////////////////////
  // register path

  spi_frame_slave u_slave (
    .cs          (cs),
    .rst_n       (rst_n),
    .sck         (sck),
    .mosi        (mosi),
    .sel_n       (sel_n),
    .sdo         (sdo),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  ctrl_reg_bank u_bank (
    .cs          (cs),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .route       (route),
    .ctrl        (ctrl)
  );

  ////////////////////
  // pass-through path

  periph_router u_router (
    .route       (route),
    .pass_n      (pass_n),
    .periph_miso (periph_miso),
    .periph_sel  (periph_sel),
    .periph_data (periph_data)
  );

  // bank select has priority over pass-through
  // both idle drives 0
  assign miso = !sel_n  ? sdo :
                !pass_n ? periph_data :
                          1'b0;

endmodule

// File: sim/spi_reg_assert.sv
////////////////////
// spi register bank assertions
// bound onto the top level
////////////////////

`timescale 1ns/100ps

`include "spi_reg_config.svh"

module spi_reg_assert (
  input logic                    cs,
  input logic                    rst_n,
  input logic                    sel_n,
  input logic                    pass_n,
  input logic                    miso,
  input logic [`NUM_PERIPH-1:0]  periph_sel,
  input spi_reg_pkg::ctrl_regs_t ctrl
);

  // idle level per line where active high lines idle low
  localparam logic [`NUM_PERIPH-1:0] SEL_IDLE = ~`SEL_POLARITY;

  // read by the testbench at the end
  int fail_count = 0;

  // writes only land after select rises
  ctrl_hold: assert property (@(posedge cs) disable iff (!rst_n)
    !sel_n |-> $stable(ctrl))
  else
  begin
    fail_count++;
    $error("ctrl changed while sel_n was low");
  end

  // one peripheral at a time
  sel_onehot: assert property (@(posedge cs) disable iff (!rst_n)
    $countones(periph_sel ^ SEL_IDLE) <= 1)
  else
  begin
    fail_count++;
    $error("more than one periph_sel line active");
  end

  // nobody selected, miso held low
  miso_idle: assert property (@(posedge cs) disable iff (!rst_n)
    (sel_n && pass_n) |-> !miso)
  else
  begin
    fail_count++;
    $error("miso high with both selects idle");
  end

endmodule

// File: sim/spi_reg_tb.sv
////////////////////
// spi register bank testbench
// table driven spi master against a register and router model
////////////////////

`timescale 1ns/100ps

`include "spi_reg_config.svh"

module spi_reg_tb;

  localparam logic [7:0] SEL_POL    = `SEL_POLARITY;
  localparam logic [1:0] MODE_BANK  = 2'd0;
  localparam logic [1:0] MODE_SHORT = 2'd1;
  localparam logic [1:0] MODE_PASS  = 2'd2;
  // sck half period in cs cycles
  localparam int HALF = 6;

  // one stimulus row
  typedef struct packed {
    logic [1:0] mode;
    logic [7:0] addr;
    // route value in pass-through rows
    logic [7:0] data;
    logic [4:0] nbits;
    // base pattern with random bits folded in
    logic [7:0] pmiso;
  } row_t;

  logic                    cs = 1'b0;
  logic                    rst_n;
  logic                    sck;
  logic                    mosi;
  logic                    sel_n;
  logic                    pass_n;
  logic [`NUM_PERIPH-1:0]  periph_miso;
  logic                    miso;
  logic [`NUM_PERIPH-1:0]  periph_sel;
  spi_reg_pkg::ctrl_regs_t ctrl;

  ////////////////////
  // table and model state

  row_t  rows[$];
  string names[$];

  spi_reg_pkg::ctrl_regs_t m_ctrl;
  logic [7:0]              m_route;
  logic [31:0]             lfsr = 32'h6482;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int failed_tests = 0;
  int cycles = 0;
  int limit = 0;

  spi_reg_top DUT (
    .cs          (cs),
    .rst_n       (rst_n),
    .sck         (sck),
    .mosi        (mosi),
    .sel_n       (sel_n),
    .pass_n      (pass_n),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_sel  (periph_sel),
    .ctrl        (ctrl)
  );

  bind spi_reg_top spi_reg_assert u_assert (
    .cs         (cs),
    .rst_n      (rst_n),
    .sel_n      (sel_n),
    .pass_n     (pass_n),
    .miso       (miso),
    .periph_sel (periph_sel),
    .ctrl       (ctrl)
  );

  // 100 ns clock
  always #50 cs = ~cs;

  // run limit from table length
  always @(posedge cs)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit)
    begin
      $display("run stopped after %0d cycles, a test never finished", cycles);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////
  // helpers

  task automatic check(input string name, input string what,
                       input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic rand_byte(output logic [7:0] val);
    val = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  // low nibble sets, high nibble clears, overlap toggles only
  function automatic logic [3:0] expect_nibble(input logic [3:0] old,
                                               input logic [7:0] data);
    logic [3:0] s;
    logic [3:0] c;
    logic [3:0] r;
    s = data[3:0];
    c = data[7:4];
    for (int b = 0; b < 4; b++)
    begin
      if ((s & c) != 4'h0)
        r[b] = (s[b] && c[b]) ? !old[b] : old[b];
      else if (c[b])
        r[b] = 1'b0;
      else
        r[b] = s[b] | old[b];
    end
    expect_nibble = r;
  endfunction

  // expected read-back byte for an address
  function automatic logic [7:0] read_model(input logic [7:0] addr);
    read_model = 8'h00;
    if (addr == spi_reg_pkg::REG_ROUTE)
      read_model = m_route;
    else if (addr == spi_reg_pkg::REG_LED)
      read_model = {4'h0, m_ctrl.led};
    else if (addr == spi_reg_pkg::REG_AUX)
      read_model = {4'h0, m_ctrl.aux};
    else if (addr == spi_reg_pkg::REG_DAC)
      read_model = {4'h0, m_ctrl.dac};
    else if (addr == spi_reg_pkg::REG_ADC)
      read_model = {4'h0, m_ctrl.adc};
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
    if (addr == spi_reg_pkg::REG_ROUTE)
      m_route = data;
    else if (addr == spi_reg_pkg::REG_LED)
      m_ctrl.led = expect_nibble(m_ctrl.led, data);
    else if (addr == spi_reg_pkg::REG_AUX)
      m_ctrl.aux = expect_nibble(m_ctrl.aux, data);
    else if (addr == spi_reg_pkg::REG_DAC)
      m_ctrl.dac = expect_nibble(m_ctrl.dac, data);
    else if (addr == spi_reg_pkg::REG_ADC)
      m_ctrl.adc = expect_nibble(m_ctrl.adc, data);
    else if (addr == spi_reg_pkg::REG_SOFT_RST)
    begin
      // aux survives
      m_ctrl.led = 4'h0;
      m_ctrl.dac = 4'h0;
      m_ctrl.adc = 4'h0;
      m_route    = 8'h00;
    end
    else if (addr == spi_reg_pkg::REG_PWRUP)
    begin
      m_ctrl.led = 4'h0;
      m_ctrl.adc = 4'h0;
    end
  endtask

  task automatic add_row(input string name, input logic [1:0] mode,
                         input logic [7:0] addr, input logic [7:0] data,
                         input logic [4:0] nbits, input logic [7:0] pmiso);
    rows.push_back('{mode, addr, data, nbits, pmiso});
    names.push_back(name);
  endtask

  task automatic build_table();
    add_row("route_write", MODE_BANK, spi_reg_pkg::REG_ROUTE, 8'h5a, 5'd16, 8'h00);
    add_row("route_read", MODE_BANK, spi_reg_pkg::REG_ROUTE, 8'h21, 5'd16, 8'h00);
    add_row("led_set", MODE_BANK, spi_reg_pkg::REG_LED, 8'h05, 5'd16, 8'h00);
    add_row("led_clear", MODE_BANK, spi_reg_pkg::REG_LED, 8'h10, 5'd16, 8'h00);
    add_row("led_toggle", MODE_BANK, spi_reg_pkg::REG_LED, 8'h66, 5'd16, 8'h00);
    add_row("dac_clear", MODE_BANK, spi_reg_pkg::REG_DAC, 8'h30, 5'd16, 8'h00);
    add_row("dac_toggle", MODE_BANK, spi_reg_pkg::REG_DAC, 8'h99, 5'd16, 8'h00);
    add_row("aux_set", MODE_BANK, spi_reg_pkg::REG_AUX, 8'h0a, 5'd16, 8'h00);
    add_row("adc_set", MODE_BANK, spi_reg_pkg::REG_ADC, 8'h03, 5'd16, 8'h00);
    add_row("pwrup", MODE_BANK, spi_reg_pkg::REG_PWRUP, 8'h00, 5'd16, 8'h00);
    add_row("led_set_2", MODE_BANK, spi_reg_pkg::REG_LED, 8'h09, 5'd16, 8'h00);
    add_row("adc_set_2", MODE_BANK, spi_reg_pkg::REG_ADC, 8'h0c, 5'd16, 8'h00);
    add_row("adc_toggle", MODE_BANK, spi_reg_pkg::REG_ADC, 8'h44, 5'd16, 8'h00);
    add_row("route_write_2", MODE_BANK, spi_reg_pkg::REG_ROUTE, 8'h33, 5'd16, 8'h00);
    add_row("soft_rst", MODE_BANK, spi_reg_pkg::REG_SOFT_RST, 8'h00, 5'd16, 8'h00);
    // 12 bit frame must be dropped
    add_row("short_led", MODE_SHORT, spi_reg_pkg::REG_LED, 8'h0f, 5'd12, 8'h00);
    add_row("led_read", MODE_BANK, spi_reg_pkg::REG_LED, 8'h00, 5'd16, 8'h00);
    add_row("aux_read", MODE_BANK, spi_reg_pkg::REG_AUX, 8'h00, 5'd16, 8'h00);
    for (int r = 0; r < 10; r++)
      add_row($sformatf("pass_route_%0d", r), MODE_PASS, spi_reg_pkg::REG_ROUTE,
              8'(r), 5'd16, 8'(r * 17));
  endtask

  ////////////////////
  // spi master

  // mode 0 msb first with miso collected in the data byte
  task automatic spi_frame(input logic [15:0] word, input int nbits,
                           output logic [7:0] rd);
    rd = 8'h00;
    @(posedge cs);
    sel_n <= 1'b0;
    repeat (HALF) @(posedge cs);
    for (int i = 0; i < nbits; i++)
    begin
      sck  <= 1'b0;
      mosi <= word[15 - i];
      repeat (HALF - 1) @(posedge cs);
      // miso settled by the end of the low half
      @(negedge cs);
      if (i >= 8)
        rd = {rd[6:0], miso};
      @(posedge cs);
      sck <= 1'b1;
      repeat (HALF) @(posedge cs);
    end
    sck <= 1'b0;
    repeat (HALF) @(posedge cs);
    sel_n <= 1'b1;
    // commit lands 4 cycles after the select rise
    repeat (8) @(posedge cs);
  endtask

  task automatic pass_through(input string name, input logic [7:0] base);
    logic [7:0] pm;
    logic [7:0] exp_sel;
    logic       exp_miso;
    rand_byte(pm);
    pm = pm ^ base;
    @(posedge cs);
    periph_miso <= pm;
    pass_n      <= 1'b0;
    repeat (2) @(posedge cs);
    @(negedge cs);
    // selected line driven to its active level
    for (int i = 0; i < 8; i++)
      exp_sel[i] = SEL_POL[i] ? (m_route == 8'(i + 1)) : (m_route != 8'(i + 1));
    exp_miso = (m_route >= 8'd1 && m_route <= 8'd8) ? pm[3'(m_route - 8'd1)] : 1'b0;
    check(name, "periph_sel", {8'h00, exp_sel}, {8'h00, periph_sel});
    check(name, "miso", {15'h0000, exp_miso}, {15'h0000, miso});
    @(posedge cs);
    pass_n <= 1'b1;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before)
      $display("%s: ok", name);
    else
    begin
      failed_tests++;
      $display("%s: mismatch", name);
    end
  endtask

  task automatic run_row(input int idx);
    row_t       r;
    logic [7:0] rd;
    logic [7:0] exp_rd;
    int         errs_before;
    r           = rows[idx];
    errs_before = errors;
    exp_rd      = read_model(r.addr);
    spi_frame({r.addr, r.data}, int'(r.nbits), rd);
    if (r.mode != MODE_SHORT)
    begin
      check(names[idx], "read", {8'h00, exp_rd}, {8'h00, rd});
      model_write(r.addr, r.data);
    end
    @(negedge cs);
    check(names[idx], "ctrl", m_ctrl, ctrl);
    check(names[idx], "idle periph_sel", {8'h00, ~SEL_POL}, {8'h00, periph_sel});
    if (r.mode == MODE_PASS)
      pass_through(names[idx], r.pmiso);
    report_test(names[idx], errs_before);
  endtask

  ////////////////////
  // main sequence

  initial
  begin
    rst_n       = 1'b0;
    sck         = 1'b0;
    mosi        = 1'b0;
    sel_n       = 1'b1;
    pass_n      = 1'b1;
    periph_miso = '0;
    m_ctrl      = '{led: 4'h0, aux: 4'h0, dac: 4'hf, adc: 4'h0};
    m_route     = 8'h00;
    build_table();
    limit = rows.size() * (`FRAME_BITS * 12 + 20) * 2;
    repeat (8) @(posedge cs);
    rst_n <= 1'b1;
    repeat (2) @(posedge cs);
    @(negedge cs);
    check("reset", "ctrl", m_ctrl, ctrl);
    check("reset", "periph_sel", {8'h00, ~SEL_POL}, {8'h00, periph_sel});
    report_test("reset", 0);
    for (int i = 0; i < rows.size(); i++)
      run_row(i);
    errors = errors + DUT.u_assert.fail_count;
    $display("%0d tests, %0d failed, %0d checks, %0d assertion failures",
             tests, failed_tests, checks, DUT.u_assert.fail_count);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: spi_reg.f
+incdir+hdl
hdl/spi_reg_pkg.sv
hdl/spi_frame_slave.sv
hdl/ctrl_reg_bank.sv
hdl/periph_router.sv
hdl/spi_reg_top.sv
sim/spi_reg_assert.sv
sim/spi_reg_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the spi register bank testbench with verilator
# exits non-zero on build error, simulator error or a failing test

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module spi_reg_tb -f spi_reg.f -o spi_reg_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# raise the error limit so every assertion failure is counted
./obj_dir/spi_reg_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi

exit 0
